// File: keypad_calc.f
hw/calc_pkg.sv
hw/bcd_conv_if.sv
hw/keypad_scanner.sv
hw/calc_core.sv
hw/bin_to_bcd.sv
hw/keypad_calc_top.sv
dv/keypad_calc_sva.sv
dv/keypad_calc_checker.sv
dv/keypad_calc_tb.sv

// File: dv/keypad_calc_stimulus.txt
# K <key code, hex> <hold ticks> <release ticks>
# R <expected result, decimal>
K e 1 1
K 0 1 1
K 1 2 1
K 2 1 1
K 3 1 2
K 4 1 1
K 5 1 1
K 6 3 1
K 7 1 1
K 8 1 1
K 9 1 2
K a 1 1
K b 2 1
K c 1 1
K d 1 1
K e 1 1
R 123
K f 1 1
K e 1 1
R 0
K 8 1 1
K 7 2 1
K a 1 1
K e 1 2
R 18014398509481982
K 0 1 1
K 1 1 1
K 2 1 1
K b 1 1
K 4 1 1
K 5 1 1
K 6 1 1
K e 1 1
R 56088
K 0 1 1
K d 1 1
K d 1 1
K f 1 1
K 8 1 1
K e 1 1
R 14
K 5 1 1
K c 1 1
K 9 1 1
K 3 1 1
K 1 1 1
K e 1 1
R 10
K a 1 1
K a 1 1
K a 1 1
K a 1 1
K a 1 1
K b 1 1
K a 1 1
K a 1 1
K a 1 1
K a 1 1
K a 1 1
K e 1 1
R 9999800001
K a 1 1
K f 1 1
K d 1 1
K e 1 1
R 0

// File: dv/keypad_calc_tb.sv
module keypad_calc_tb
    import calc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK = 16;   // Clocks per scan step

    logic                    clk;
    logic                    reset_p = 1'b1;
    logic [3:0]              row = 4'b0000;
    logic [3:0]              col;
    key_code_t               key_value;
    logic                    key_valid;
    logic [RESULT_W-1:0]     result;
    logic [4*BCD_DIGITS-1:0] result_bcd;
    logic                    result_ready;

    // Keypad model state
    logic [1:0] press_row = 2'd0;
    logic [1:0] press_col = 2'd0;
    logic       pressed = 1'b0;
    key_code_t  pressed_code = '0;

    int     key_code_q[$];
    int     hold_q[$];
    int     rel_q[$];
    longint budget_ns = 0;
    bit     loaded = 1'b0;
    int     other_errors = 0;

    keypad_calc_top #(.SCAN_TICK_CYCLES(TICK)) dut (.*);

    keypad_calc_checker #(.RESULT_W(RESULT_W), .BCD_DIGITS(BCD_DIGITS)) chk (.*);

    bind keypad_calc_top keypad_calc_sva #(.RESULT_W(RESULT_W)) u_sva (
        .clk          (clk),
        .reset_p      (reset_p),
        .col          (col),
        .key_valid    (key_valid),
        .result_ready (result_ready),
        .conv_start   (conv.start)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Row answers only while the pressed column is driven
    always @(posedge clk) begin
        if (pressed && col[press_col])
            row <= 4'b0001 << press_row;
        else
            row <= 4'b0000;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic load_stimulus(output bit ok);
        int          fd;
        logic [7:0]  tag;
        int          code;
        int          hold;
        int          rel;
        logic [63:0] value;
        logic [8*160-1:0] skip_line;
        fd = $fopen("dv/keypad_calc_stimulus.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            budget_ns = 64'(10 * TICK * 20);   // Reset and final drain
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "K") begin
                    void'($fscanf(fd, "%h %d %d", code, hold, rel));
                    key_code_q.push_back(code);
                    hold_q.push_back(hold);
                    rel_q.push_back(rel);
                    budget_ns += 64'((hold + rel + 8) * TICK * 20);
                end else if (tag == "R") begin
                    void'($fscanf(fd, "%d", value));
                    chk.expect_result(value);
                end else begin
                    void'($fgets(skip_line, fd));
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_key_valid(input logic level, output bit ok);
        int n;
        n = 0;
        while (key_valid !== level && n < 8 * TICK) begin
            @(posedge clk);
            n++;
        end
        ok = (key_valid === level);
    endtask

    task automatic press_key(input key_code_t code, input int hold, input int rel);
        bit ok;
        @(posedge clk);
        press_row    <= code[3:2];
        press_col    <= code[1:0];
        pressed_code <= code;
        pressed      <= 1'b1;
        wait_key_valid(1'b1, ok);
        if (!ok) begin
            other_errors++;
            $display("key_valid never rose for key %h at %0t", code, $time);
        end
        repeat (hold * TICK) @(posedge clk);
        @(posedge clk);
        pressed <= 1'b0;
        wait_key_valid(1'b0, ok);
        if (!ok) begin
            other_errors++;
            $display("key_valid stayed high after release of key %h at %0t", code, $time);
        end
        repeat ((rel + $urandom_range(3)) * TICK) @(posedge clk);   // Idle gap
    endtask

    initial begin : main
        bit ok;
        void'($urandom(37414));
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not open dv/keypad_calc_stimulus.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            reset_p <= 1'b0;
            foreach (key_code_q[i])
                press_key(key_code_q[i], hold_q[i], rel_q[i]);
            repeat (2 * TICK) @(posedge clk);
            if (chk.pending_results() != 0) begin
                other_errors++;
                $display("%0d expected results were never produced", chk.pending_results());
            end
            $display("Errors: key %0d, result %0d, assertion %0d, other %0d",
                     chk.key_errors, chk.result_errors, dut.u_sva.assert_errors,
                     other_errors);
            if (chk.key_errors + chk.result_errors + dut.u_sva.assert_errors
                    + other_errors == 0)
                $display("TEST OK");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : watchdog
        wait (loaded);
        #(budget_ns);
        $display("Run timed out before the stimulus was finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: dv/keypad_calc_checker.sv
module keypad_calc_checker
    import calc_pkg::*;
#(
    parameter int RESULT_W   = calc_pkg::RESULT_W,
    parameter int BCD_DIGITS = calc_pkg::BCD_DIGITS
) (
    input logic                    clk,
    input logic                    reset_p,
    input key_code_t               pressed_code,   // From the keypad model
    input key_code_t               key_value,
    input logic                    key_valid,
    input logic [RESULT_W-1:0]     result,
    input logic [4*BCD_DIGITS-1:0] result_bcd,
    input logic                    result_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [RESULT_W-1:0] expected_q[$];
    logic                key_valid_d;
    int                  key_errors = 0;
    int                  result_errors = 0;

    // Decimal digits by repeated division, low digit in the low nibble
    function automatic logic [4*BCD_DIGITS-1:0] decimal_digits(input logic [RESULT_W-1:0] v);
        logic [4*BCD_DIGITS-1:0] d;
        logic [RESULT_W-1:0]     rest;
        d    = '0;
        rest = v;
        for (int i = 0; i < BCD_DIGITS; i++) begin
            d[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return d;
    endfunction

    task automatic expect_result(input logic [63:0] v);
        expected_q.push_back(RESULT_W'(v));
    endtask

    function automatic int pending_results();
        return expected_q.size();
    endfunction

    task automatic check_result();
        logic [RESULT_W-1:0] exp_value;
        if (expected_q.size() == 0) begin
            result_errors++;
            $display("CHECK FAILED at %0t: unexpected result_ready, result %0d", $time, result);
        end else begin
            exp_value = expected_q.pop_front();
            if (result !== exp_value) begin
                result_errors++;
                $display("CHECK FAILED at %0t: result %0d, expected %0d",
                         $time, result, exp_value);
            end
            if (result_bcd !== decimal_digits(exp_value)) begin
                result_errors++;
                $display("CHECK FAILED at %0t: result_bcd %h, expected %h",
                         $time, result_bcd, decimal_digits(exp_value));
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset_p) begin
            key_valid_d <= 1'b0;
        end else begin
            key_valid_d <= key_valid;
            if (key_valid && !key_valid_d && key_value !== pressed_code) begin
                key_errors++;
                $display("CHECK FAILED at %0t: key_value %h, expected %h",
                         $time, key_value, pressed_code);
            end
            if (result_ready)
                check_result();
        end
    end

endmodule

// File: dv/keypad_calc_sva.sv
module keypad_calc_sva
    import calc_pkg::*;
#(
    parameter int RESULT_W = calc_pkg::RESULT_W
) (
    input logic       clk,
    input logic       reset_p,
    input logic [3:0] col,
    input logic       key_valid,
    input logic       result_ready,
    input logic       conv_start
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors = 0;

    col_onehot: assert property (@(posedge clk) disable iff (reset_p) $onehot(col))
        else begin
            assert_errors++;
            $error("col is not one-hot");
        end

    // Column frozen for the whole press
    col_frozen: assert property (@(posedge clk) disable iff (reset_p)
        key_valid && $past(key_valid) |-> $stable(col))
        else begin
            assert_errors++;
            $error("col moved while key_valid was high");
        end

    ready_pulse: assert property (@(posedge clk) disable iff (reset_p)
        result_ready |=> !result_ready)
        else begin
            assert_errors++;
            $error("result_ready lasted more than one cycle");
        end

    conv_latency: assert property (@(posedge clk) disable iff (reset_p)
        conv_start |-> ##(RESULT_W + 1) result_ready)
        else begin
            assert_errors++;
            $error("result_ready did not follow start by RESULT_W + 1 cycles");
        end

endmodule

// File: hw/keypad_calc_top.sv
module keypad_calc_top
    import calc_pkg::*;
#(
    parameter int OPERAND_W        = calc_pkg::OPERAND_W,
    parameter int RESULT_W         = calc_pkg::RESULT_W,
    parameter int BCD_DIGITS       = calc_pkg::BCD_DIGITS,
    parameter int SCAN_TICK_CYCLES = calc_pkg::SCAN_TICK_CYCLES
) (
    input  logic                    clk,
    input  logic                    reset_p,
    input  logic [3:0]              row,
    output logic [3:0]              col,
    output key_code_t               key_value,
    output logic                    key_valid,
    output logic [RESULT_W-1:0]     result,
    output logic [4*BCD_DIGITS-1:0] result_bcd,
    output logic                    result_ready
);

    bcd_conv_if #(.RESULT_W(RESULT_W), .BCD_DIGITS(BCD_DIGITS)) conv ();

    keypad_scanner #(.SCAN_TICK_CYCLES(SCAN_TICK_CYCLES)) u_scanner (
        .clk       (clk),
        .reset_p   (reset_p),
        .row       (row),
        .col       (col),
        .key_value (key_value),
        .key_valid (key_valid)
    );

    calc_core #(.OPERAND_W(OPERAND_W), .RESULT_W(RESULT_W)) u_calc (
        .clk       (clk),
        .reset_p   (reset_p),
        .key_value (key_value),
        .key_valid (key_valid),
        .result    (result),
        .conv      (conv.calc_side)
    );

    bin_to_bcd #(.RESULT_W(RESULT_W), .BCD_DIGITS(BCD_DIGITS)) u_bcd (
        .clk     (clk),
        .reset_p (reset_p),
        .conv    (conv.conv_side)
    );

    assign result_bcd   = conv.bcd;
    assign result_ready = conv.done;   // One-cycle pulse

endmodule

// File: hw/bin_to_bcd.sv
module bin_to_bcd
    import calc_pkg::*;
#(
    parameter int RESULT_W   = calc_pkg::RESULT_W,
    parameter int BCD_DIGITS = calc_pkg::BCD_DIGITS
) (
    input  logic          clk,
    input  logic          reset_p,
    bcd_conv_if.conv_side conv
);

    localparam int BCD_W = 4 * BCD_DIGITS;
    localparam int CNT_W = $clog2(RESULT_W + 1);

    logic             busy;
    logic [CNT_W-1:0] shift_cnt;
    logic [RESULT_W-1:0] bin_sr;
    logic [BCD_W-1:0] digits;
    logic [BCD_W-1:0] digits_adj;
    logic [BCD_W-1:0] digits_next;

    ////////////////////////////////////////////////////////////////////
    // Shift-and-add-3 datapath
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < BCD_DIGITS; i++) begin
            if (digits[4*i +: 4] >= 4'd5)
                digits_adj[4*i +: 4] = digits[4*i +: 4] + 4'd3;
            else
                digits_adj[4*i +: 4] = digits[4*i +: 4];
        end
    end

    // Top digit overflow drops out, giving mod 10^BCD_DIGITS
    assign digits_next = {digits_adj[BCD_W-2:0], bin_sr[RESULT_W-1]};

    always_ff @(posedge clk) begin
        if (!busy && conv.start) begin
            bin_sr <= conv.bin;
            digits <= '0;
        end else if (busy) begin
            bin_sr <= bin_sr << 1;
            digits <= digits_next;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Control, done lands RESULT_W + 1 cycles after start
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            busy      <= 1'b0;
            shift_cnt <= '0;
            conv.done <= 1'b0;
            conv.bcd  <= '0;
        end else begin
            conv.done <= 1'b0;
            if (!busy) begin
                if (conv.start) begin   // Start while busy is ignored
                    busy      <= 1'b1;
                    shift_cnt <= '0;
                end
            end else begin
                shift_cnt <= shift_cnt + 1'b1;
                if (shift_cnt == CNT_W'(RESULT_W - 1)) begin   // Last shift
                    busy      <= 1'b0;
                    conv.bcd  <= digits_next;
                    conv.done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/calc_core.sv
module calc_core
    import calc_pkg::*;
#(
    parameter int OPERAND_W = calc_pkg::OPERAND_W,
    parameter int RESULT_W  = calc_pkg::RESULT_W
) (
    input  logic                clk,
    input  logic                reset_p,
    input  key_code_t           key_value,
    input  logic                key_valid,
    output logic [RESULT_W-1:0] result,
    bcd_conv_if.calc_side       conv
);

    logic                 key_valid_d;
    logic                 key_press;
    logic                 second_stage;   // Entering operand b
    calc_op_t             op;
    calc_op_t             key_op;
    logic [3:0]           digit;
    logic                 is_digit;
    logic [OPERAND_W-1:0] operand_a;
    logic [OPERAND_W-1:0] operand_b;
    logic [OPERAND_W-1:0] cur_operand;
    logic [OPERAND_W-1:0] entered;
    logic [RESULT_W-1:0]  ext_a;
    logic [RESULT_W-1:0]  ext_b;
    logic [RESULT_W-1:0]  alu_out;

    // 4'hf marks a non-digit key
    function automatic logic [3:0] key_digit(input key_code_t k);
        case (k)
            KEY_0:   return 4'd0;
            KEY_1:   return 4'd1;
            KEY_2:   return 4'd2;
            KEY_3:   return 4'd3;
            KEY_4:   return 4'd4;
            KEY_5:   return 4'd5;
            KEY_6:   return 4'd6;
            KEY_7:   return 4'd7;
            KEY_8:   return 4'd8;
            KEY_9:   return 4'd9;
            default: return 4'hf;
        endcase
    endfunction

    function automatic calc_op_t key_operator(input key_code_t k);
        case (k)
            KEY_ADD: return OP_ADD;
            KEY_SUB: return OP_SUB;
            KEY_MUL: return OP_MUL;
            KEY_DIV: return OP_DIV;
            default: return OP_NONE;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Key decode and operand entry
    ////////////////////////////////////////////////////////////////////
    assign key_press   = key_valid & ~key_valid_d;
    assign digit       = key_digit(key_value);
    assign is_digit    = (digit != 4'hf);
    assign key_op      = key_operator(key_value);
    assign cur_operand = second_stage ? operand_b : operand_a;
    assign entered     = cur_operand * OPERAND_W'(10) + OPERAND_W'(digit);   // Wraps

    assign ext_a = RESULT_W'(operand_a);
    assign ext_b = RESULT_W'(operand_b);

    always_comb begin
        case (op)
            OP_ADD:  alu_out = ext_a + ext_b;
            OP_SUB:  alu_out = ext_a - ext_b;
            OP_MUL:  alu_out = ext_a * ext_b;
            OP_DIV:  alu_out = (operand_b == '0) ? '0 : ext_a / ext_b;
            default: alu_out = '0;
        endcase
    end

    assign conv.bin = result;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            key_valid_d  <= 1'b0;
            second_stage <= 1'b0;
            op           <= OP_NONE;
            operand_a    <= '0;
            operand_b    <= '0;
            result       <= '0;
            conv.start   <= 1'b0;
        end else begin
            key_valid_d <= key_valid;
            conv.start  <= 1'b0;
            if (key_press) begin
                if (is_digit) begin
                    if (second_stage)
                        operand_b <= entered;
                    else
                        operand_a <= entered;
                end else if (key_value == KEY_CLEAR) begin
                    if (second_stage)
                        operand_b <= '0;
                    else
                        operand_a <= '0;
                end else if (key_op != OP_NONE) begin
                    if (!second_stage) begin   // Extra operator ignored
                        op           <= key_op;
                        second_stage <= 1'b1;
                    end
                end else if (key_value == KEY_EQUALS && second_stage) begin
                    result       <= alu_out;
                    conv.start   <= 1'b1;
                    operand_a    <= '0;
                    operand_b    <= '0;
                    op           <= OP_NONE;
                    second_stage <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hw/keypad_scanner.sv
module keypad_scanner
    import calc_pkg::*;
#(
    parameter int SCAN_TICK_CYCLES = calc_pkg::SCAN_TICK_CYCLES
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] row,
    output logic [3:0] col,
    output key_code_t  key_value,
    output logic       key_valid
);

    localparam int TICK_W = (SCAN_TICK_CYCLES > 1) ? $clog2(SCAN_TICK_CYCLES) : 1;

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    scan_state_t       state;

    // Index of the lowest set bit, row 0 wins on multi-press
    function automatic logic [1:0] low_index(input logic [3:0] v);
        if (v[0])
            return 2'd0;
        else if (v[1])
            return 2'd1;
        else if (v[2])
            return 2'd2;
        else
            return 2'd3;
    endfunction

    function automatic scan_state_t next_scan(input scan_state_t s);
        case (s)
            SCAN_0:  return SCAN_1;
            SCAN_1:  return SCAN_2;
            SCAN_2:  return SCAN_3;
            default: return SCAN_0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Scan tick divider
    ////////////////////////////////////////////////////////////////////
    assign tick = (tick_cnt == TICK_W'(SCAN_TICK_CYCLES - 1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    ////////////////////////////////////////////////////////////////////
    // Column scan FSM
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state     <= SCAN_0;
            col       <= 4'b0001;
            key_value <= '0;
            key_valid <= 1'b0;
        end else if (tick) begin
            case (state)
                SCAN_0, SCAN_1, SCAN_2, SCAN_3: begin
                    if (row != 4'b0000) begin
                        state     <= KEY_HELD;   // col stays frozen
                        key_valid <= 1'b1;
                        key_value <= {low_index(row), low_index(col)};
                    end else begin
                        state <= next_scan(state);
                        col   <= {col[2:0], col[3]};
                    end
                end
                KEY_HELD: begin
                    if (row == 4'b0000) begin   // Released
                        state     <= SCAN_0;
                        col       <= 4'b0001;
                        key_valid <= 1'b0;
                    end
                end
                default: begin
                    state     <= SCAN_0;
                    col       <= 4'b0001;
                    key_valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hw/bcd_conv_if.sv
interface bcd_conv_if #(
    parameter int RESULT_W   = calc_pkg::RESULT_W,
    parameter int BCD_DIGITS = calc_pkg::BCD_DIGITS
);

    logic                    start;   // One-cycle pulse
    logic [RESULT_W-1:0]     bin;
    logic [4*BCD_DIGITS-1:0] bcd;     // Packed, digit 0 in low nibble
    logic                    done;    // One-cycle pulse

    modport calc_side (
        output start, bin,
        input  bcd, done
    );

    modport conv_side (
        input  start, bin,
        output bcd, done
    );

endinterface

// File: hw/calc_pkg.sv
package calc_pkg;

    ////////////////////////////////////////////////////////////////////
    // Keypad codes, row * 4 + col
    ////////////////////////////////////////////////////////////////////
    typedef logic [3:0] key_code_t;

    localparam key_code_t KEY_1      = 4'h0;
    localparam key_code_t KEY_2      = 4'h1;
    localparam key_code_t KEY_3      = 4'h2;
    localparam key_code_t KEY_ADD    = 4'h3;
    localparam key_code_t KEY_4      = 4'h4;
    localparam key_code_t KEY_5      = 4'h5;
    localparam key_code_t KEY_6      = 4'h6;
    localparam key_code_t KEY_SUB    = 4'h7;
    localparam key_code_t KEY_7      = 4'h8;
    localparam key_code_t KEY_8      = 4'h9;
    localparam key_code_t KEY_9      = 4'ha;
    localparam key_code_t KEY_MUL    = 4'hb;
    localparam key_code_t KEY_CLEAR  = 4'hc;
    localparam key_code_t KEY_0      = 4'hd;
    localparam key_code_t KEY_EQUALS = 4'he;
    localparam key_code_t KEY_DIV    = 4'hf;

    typedef enum logic [4:0] {
        SCAN_0   = 5'b00001,
        SCAN_1   = 5'b00010,
        SCAN_2   = 5'b00100,
        SCAN_3   = 5'b01000,
        KEY_HELD = 5'b10000
    } scan_state_t;

    typedef enum logic [2:0] {OP_NONE, OP_ADD, OP_SUB, OP_MUL, OP_DIV} calc_op_t;

    localparam int OPERAND_W        = 32;
    localparam int RESULT_W         = 54;
    localparam int BCD_DIGITS       = 16;
    localparam int SCAN_TICK_CYCLES = 32768;   // Clocks per column step

endpackage
